//--- logic/mpss_pkg.sv
package mpss_pkg;

	// Fabric size
	localparam int N_MASTERS = 2;
	localparam int N_TARGETS = 3;

	// Address map, select in addr[13:12]
	localparam int SEL_LSB = 12;
	localparam int SEL_W = 2;
	localparam int N_SELECTS = 2 ** SEL_W;
	localparam int SEL_UNMAPPED = N_SELECTS - 1;

	localparam int RAM_WORDS = 256;
	localparam int RAM_IDX_W = $clog2(RAM_WORDS);

	localparam int HOST_QUEUE_DEPTH = 4;

	// Byte offsets of the GPIO words
	localparam int GPIO_OUT_OFS = 0;
	localparam int GPIO_IN_OFS = 4;

	typedef logic [31:0] data_t;
	typedef logic [31:0] addr_t;
	typedef logic [3:0] be_t;
	typedef logic [0:0] mid_t;
	typedef logic [SEL_W-1:0] sid_t;

	typedef logic [RAM_IDX_W-1:0] ram_idx_t;
	typedef logic [SEL_LSB-1:0] ofs_t; // Offset inside a target window
	typedef logic [$clog2(HOST_QUEUE_DEPTH)-1:0] qptr_t;
	typedef logic [$clog2(HOST_QUEUE_DEPTH+1)-1:0] qcnt_t;

	// Command and bus request, same layout on both sides
	typedef struct packed {
		logic  we;
		addr_t addr;
		be_t   be;
		data_t wdata;
	} bus_req_t;

	typedef enum logic [1:0] {
		HOST_IDLE,
		HOST_REQ,
		HOST_WAIT_RESP
	} host_state_e;

endpackage

//--- logic/reset_cntrl.sv
module reset_cntrl
(
	input  logic   clk_i
	, input  logic arst_n_i
	, output logic rst_n_o
);

	logic [1:0] sync;

	// Assert at once, release after two edges
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sync <= 2'b00;
		end else begin
			sync <= {sync[0], 1'b1};
		end
	end

	assign rst_n_o = sync[1];

endmodule

//--- logic/bus_host.sv
module bus_host
	import mpss_pkg::*;
(
	input  logic       clk_i
	, input  logic     arst_n_i

	, input  logic     cmd_valid_i
	, input  bus_req_t cmd_i
	, output logic     cmd_full_o

	, output logic     rsp_valid_o
	, output data_t    rsp_rdata_o

	, output logic     bus_req_o
	, output bus_req_t bus_o
	, input  logic     bus_ack_i
	, input  logic     bus_resp_i
	, input  data_t    bus_rdata_i
);

	bus_req_t queue [HOST_QUEUE_DEPTH];
	qptr_t wr_ptr;
	qptr_t rd_ptr;
	qcnt_t count;
	host_state_e state;
	logic push;
	logic pop;

	assign cmd_full_o = (count == qcnt_t'(HOST_QUEUE_DEPTH));
	assign push = cmd_valid_i && !cmd_full_o; // Strobes while full are dropped
	assign pop = (state == HOST_IDLE) && (count != '0);
	assign bus_req_o = (state == HOST_REQ);

	always_ff @(posedge clk_i) begin
		if (push) begin
			queue[wr_ptr] <= cmd_i;
		end
		if (pop) begin
			bus_o <= queue[rd_ptr]; // Held until ack
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// One transaction at a time, reads wait for resp
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state <= HOST_IDLE;
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= 1'b0;
			case (state)
				HOST_IDLE: begin
					if (pop) begin
						state <= HOST_REQ;
					end
				end
				HOST_REQ: begin
					if (bus_ack_i) begin
						state <= bus_o.we ? HOST_IDLE : HOST_WAIT_RESP;
					end
				end
				HOST_WAIT_RESP: begin
					if (bus_resp_i) begin
						state <= HOST_IDLE;
						rsp_valid_o <= 1'b1;
					end
				end
				default: state <= HOST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if ((state == HOST_WAIT_RESP) && bus_resp_i) begin
			rsp_rdata_o <= bus_rdata_i;
		end
	end

endmodule

//--- logic/xbar_buffered.sv
module xbar_buffered
	import mpss_pkg::*;
(
	input  logic                   clk_i
	, input  logic                 arst_n_i

	, input  logic [N_MASTERS-1:0] m_req_i
	, input  bus_req_t             m_bus_i [N_MASTERS]
	, output logic [N_MASTERS-1:0] m_ack_o
	, output logic [N_MASTERS-1:0] m_resp_o
	, output data_t                m_rdata_o [N_MASTERS]

	, output logic [N_TARGETS-1:0] t_req_o
	, output bus_req_t             t_bus_o [N_TARGETS]
	, input  logic [N_TARGETS-1:0] t_ack_i
	, input  logic [N_TARGETS-1:0] t_resp_i
	, input  data_t                t_rdata_i [N_TARGETS]
);

	sid_t sel [N_MASTERS];
	logic [N_MASTERS-1:0] sel_req [N_SELECTS];
	logic [N_SELECTS-1:0] sel_free;
	logic [N_SELECTS-1:0] gnt_vld;
	mid_t gnt_mid [N_SELECTS];
	mid_t last_mid [N_SELECTS];

	// Request slices and read routing per target
	logic [N_TARGETS-1:0] slice_vld;
	bus_req_t slice_bus [N_TARGETS];
	mid_t slice_mid [N_TARGETS];
	logic [N_TARGETS-1:0] rd_vld;
	mid_t rd_mid [N_TARGETS];

	// Zero-data read for the unmapped window
	logic unm_vld;
	mid_t unm_mid;

	// Round robin, the master after last wins
	function automatic mid_t rr_pick(input logic [N_MASTERS-1:0] reqs, input mid_t last);
		mid_t pick;
		int idx;
		pick = last;
		for (int i = N_MASTERS; i >= 1; i--) begin
			idx = (int'(last) + i) % N_MASTERS;
			if (reqs[idx]) begin
				pick = mid_t'(idx);
			end
		end
		return pick;
	endfunction

	always_comb begin
		for (int m = 0; m < N_MASTERS; m++) begin
			sel[m] = m_bus_i[m].addr[SEL_LSB +: SEL_W];
		end
		for (int s = 0; s < N_SELECTS; s++) begin
			for (int m = 0; m < N_MASTERS; m++) begin
				sel_req[s][m] = m_req_i[m] && (sel[m] == sid_t'(s));
			end
		end
		for (int t = 0; t < N_TARGETS; t++) begin
			sel_free[t] = !slice_vld[t] || t_ack_i[t]; // Empty or draining
		end
		sel_free[SEL_UNMAPPED] = 1'b1;
		for (int s = 0; s < N_SELECTS; s++) begin
			gnt_vld[s] = (|sel_req[s]) && sel_free[s];
			gnt_mid[s] = rr_pick(sel_req[s], last_mid[s]);
		end
	end

	assign t_req_o = slice_vld;
	assign t_bus_o = slice_bus;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			slice_vld <= '0;
			rd_vld <= '0;
			unm_vld <= 1'b0;
			unm_mid <= '0;
			for (int s = 0; s < N_SELECTS; s++) begin
				last_mid[s] <= '0;
			end
			for (int t = 0; t < N_TARGETS; t++) begin
				slice_mid[t] <= '0;
				rd_mid[t] <= '0;
			end
		end else begin
			for (int s = 0; s < N_SELECTS; s++) begin
				if (gnt_vld[s]) begin
					last_mid[s] <= gnt_mid[s];
				end
			end
			for (int t = 0; t < N_TARGETS; t++) begin
				if (gnt_vld[t]) begin
					slice_vld[t] <= 1'b1;
					slice_mid[t] <= gnt_mid[t];
				end else if (t_ack_i[t]) begin
					slice_vld[t] <= 1'b0;
				end
				// Target answers one cycle after a read ack
				rd_vld[t] <= slice_vld[t] && t_ack_i[t] && !slice_bus[t].we;
				rd_mid[t] <= slice_mid[t];
			end
			unm_vld <= gnt_vld[SEL_UNMAPPED] && !m_bus_i[gnt_mid[SEL_UNMAPPED]].we;
			unm_mid <= gnt_mid[SEL_UNMAPPED];
		end
	end

	always_ff @(posedge clk_i) begin
		for (int t = 0; t < N_TARGETS; t++) begin
			if (gnt_vld[t]) begin
				slice_bus[t] <= m_bus_i[gnt_mid[t]];
			end
		end
	end

	always_comb begin
		m_ack_o = '0;
		m_resp_o = '0;
		for (int m = 0; m < N_MASTERS; m++) begin
			m_rdata_o[m] = '0;
		end
		for (int s = 0; s < N_SELECTS; s++) begin
			if (gnt_vld[s]) begin
				m_ack_o[gnt_mid[s]] = 1'b1;
			end
		end
		// A host has one read in flight, so no two sources collide
		for (int t = 0; t < N_TARGETS; t++) begin
			if (rd_vld[t] && t_resp_i[t]) begin
				m_resp_o[rd_mid[t]] = 1'b1;
				m_rdata_o[rd_mid[t]] = t_rdata_i[t];
			end
		end
		if (unm_vld) begin
			m_resp_o[unm_mid] = 1'b1;
		end
	end

endmodule

//--- logic/ram_bank.sv
module ram_bank
	import mpss_pkg::*;
(
	input  logic       clk_i
	, input  logic     arst_n_i

	, input  logic     bus_req_i
	, input  bus_req_t bus_i
	, output logic     bus_ack_o
	, output logic     bus_resp_o
	, output data_t    bus_rdata_o
);

	data_t mem [RAM_WORDS];
	ram_idx_t idx;

	assign idx = bus_i.addr[2 +: RAM_IDX_W]; // Word address
	assign bus_ack_o = bus_req_i; // Never stalls

	always_ff @(posedge clk_i) begin
		if (bus_req_i) begin
			if (bus_i.we) begin
				for (int b = 0; b < $bits(be_t); b++) begin
					if (bus_i.be[b]) begin
						mem[idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
					end
				end
			end else begin
				bus_rdata_o <= mem[idx];
			end
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			bus_resp_o <= 1'b0;
		end else begin
			bus_resp_o <= bus_req_i && !bus_i.we;
		end
	end

endmodule

//--- logic/gpio.sv
module gpio
	import mpss_pkg::*;
(
	input  logic       clk_i
	, input  logic     arst_n_i

	, input  logic     bus_req_i
	, input  bus_req_t bus_i
	, output logic     bus_ack_o
	, output logic     bus_resp_o
	, output data_t    bus_rdata_o

	, input  data_t    gpio_bi
	, output data_t    gpio_bo
);

	ofs_t ofs;
	data_t in_meta;
	data_t in_sync;

	assign ofs = bus_i.addr[SEL_LSB-1:0];
	assign bus_ack_o = bus_req_i;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			gpio_bo <= '0;
			in_meta <= '0;
			in_sync <= '0;
			bus_resp_o <= 1'b0;
		end else begin
			in_meta <= gpio_bi;
			in_sync <= in_meta;
			bus_resp_o <= bus_req_i && !bus_i.we;
			// Input word is read-only
			if (bus_req_i && bus_i.we && (ofs == ofs_t'(GPIO_OUT_OFS))) begin
				for (int b = 0; b < $bits(be_t); b++) begin
					if (bus_i.be[b]) begin
						gpio_bo[8*b +: 8] <= bus_i.wdata[8*b +: 8];
					end
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (bus_req_i && !bus_i.we) begin
			if (ofs == ofs_t'(GPIO_IN_OFS)) begin
				bus_rdata_o <= in_sync;
			end else if (ofs == ofs_t'(GPIO_OUT_OFS)) begin
				bus_rdata_o <= gpio_bo;
			end else begin
				bus_rdata_o <= '0;
			end
		end
	end

endmodule

//--- logic/mpss.sv
module mpss
	import mpss_pkg::*;
(
	input  logic                   clk_i
	, input  logic                 arst_n_i

	, input  logic [N_MASTERS-1:0] cmd_valid_i
	, input  bus_req_t             cmd_i [N_MASTERS]
	, output logic [N_MASTERS-1:0] cmd_full_o
	, output logic [N_MASTERS-1:0] rsp_valid_o
	, output data_t                rsp_rdata_o [N_MASTERS]

	, input  data_t                gpio_bi
	, output data_t                gpio_bo
);

	logic rst_n;

	logic [N_MASTERS-1:0] m_req;
	bus_req_t m_bus [N_MASTERS];
	logic [N_MASTERS-1:0] m_ack;
	logic [N_MASTERS-1:0] m_resp;
	data_t m_rdata [N_MASTERS];

	// Target 0 and 1 are RAM banks, 2 is GPIO
	logic [N_TARGETS-1:0] t_req;
	bus_req_t t_bus [N_TARGETS];
	logic [N_TARGETS-1:0] t_ack;
	logic [N_TARGETS-1:0] t_resp;
	data_t t_rdata [N_TARGETS];

	reset_cntrl reset_cntrl
	(
		.clk_i(clk_i)
		, .arst_n_i(arst_n_i)
		, .rst_n_o(rst_n)
	);

	bus_host host0
	(
		.clk_i(clk_i)
		, .arst_n_i(rst_n)
		, .cmd_valid_i	(cmd_valid_i[0])
		, .cmd_i		(cmd_i[0])
		, .cmd_full_o	(cmd_full_o[0])
		, .rsp_valid_o	(rsp_valid_o[0])
		, .rsp_rdata_o	(rsp_rdata_o[0])
		, .bus_req_o	(m_req[0])
		, .bus_o		(m_bus[0])
		, .bus_ack_i	(m_ack[0])
		, .bus_resp_i	(m_resp[0])
		, .bus_rdata_i	(m_rdata[0])
	);

	// Debug bridge port
	bus_host host1
	(
		.clk_i(clk_i)
		, .arst_n_i(rst_n)
		, .cmd_valid_i	(cmd_valid_i[1])
		, .cmd_i		(cmd_i[1])
		, .cmd_full_o	(cmd_full_o[1])
		, .rsp_valid_o	(rsp_valid_o[1])
		, .rsp_rdata_o	(rsp_rdata_o[1])
		, .bus_req_o	(m_req[1])
		, .bus_o		(m_bus[1])
		, .bus_ack_i	(m_ack[1])
		, .bus_resp_i	(m_resp[1])
		, .bus_rdata_i	(m_rdata[1])
	);

	xbar_buffered xbar
	(
		.clk_i(clk_i)
		, .arst_n_i(rst_n)
		, .m_req_i		(m_req)
		, .m_bus_i		(m_bus)
		, .m_ack_o		(m_ack)
		, .m_resp_o		(m_resp)
		, .m_rdata_o	(m_rdata)
		, .t_req_o		(t_req)
		, .t_bus_o		(t_bus)
		, .t_ack_i		(t_ack)
		, .t_resp_i		(t_resp)
		, .t_rdata_i	(t_rdata)
	);

	ram_bank ram0
	(
		.clk_i(clk_i)
		, .arst_n_i(rst_n)
		, .bus_req_i	(t_req[0])
		, .bus_i		(t_bus[0])
		, .bus_ack_o	(t_ack[0])
		, .bus_resp_o	(t_resp[0])
		, .bus_rdata_o	(t_rdata[0])
	);

	ram_bank ram1
	(
		.clk_i(clk_i)
		, .arst_n_i(rst_n)
		, .bus_req_i	(t_req[1])
		, .bus_i		(t_bus[1])
		, .bus_ack_o	(t_ack[1])
		, .bus_resp_o	(t_resp[1])
		, .bus_rdata_o	(t_rdata[1])
	);

	gpio gpio
	(
		.clk_i(clk_i)
		, .arst_n_i(rst_n)
		, .bus_req_i	(t_req[2])
		, .bus_i		(t_bus[2])
		, .bus_ack_o	(t_ack[2])
		, .bus_resp_o	(t_resp[2])
		, .bus_rdata_o	(t_rdata[2])
		, .gpio_bi(gpio_bi)
		, .gpio_bo(gpio_bo)
	);

endmodule

//--- test/mpss_tb_model.svh
`ifndef MPSS_TB_MODEL_SVH
`define MPSS_TB_MODEL_SVH

// Expected contents of the memory map
data_t model_ram [2][RAM_WORDS];
data_t model_gpio_out;
data_t model_gpio_in;
data_t exp_q0 [$]; // Pending read data, host 0
data_t exp_q1 [$];

function automatic addr_t map_addr(input int sel, input int byte_ofs);
	return addr_t'((sel << SEL_LSB) | byte_ofs);
endfunction

function automatic addr_t ram_addr(input int bank, input int idx);
	return map_addr(bank, idx * 4);
endfunction

function automatic data_t merge_bytes(input data_t old_word, input data_t new_word, input be_t be);
	data_t res;
	res = old_word;
	for (int b = 0; b < 4; b++) begin
		if (be[b]) begin
			res[8*b +: 8] = new_word[8*b +: 8];
		end
	end
	return res;
endfunction

// Applies a command when it is accepted by a host
function automatic void model_apply(input int host, input bus_req_t cmd);
	int sel;
	int idx;
	int ofs;
	data_t rd;
	sel = (cmd.addr >> SEL_LSB) & 3;
	idx = (cmd.addr >> 2) & (RAM_WORDS - 1);
	ofs = cmd.addr & ((1 << SEL_LSB) - 1);
	rd = '0; // Unmapped reads answer zero
	if (sel < 2) begin
		if (cmd.we) model_ram[sel][idx] = merge_bytes(model_ram[sel][idx], cmd.wdata, cmd.be);
		rd = model_ram[sel][idx];
	end else if (sel == 2) begin
		if (ofs == GPIO_OUT_OFS) begin
			if (cmd.we) model_gpio_out = merge_bytes(model_gpio_out, cmd.wdata, cmd.be);
			rd = model_gpio_out;
		end else if (ofs == GPIO_IN_OFS) begin
			rd = model_gpio_in;
		end
	end
	if (!cmd.we) begin
		if (host == 0) exp_q0.push_back(rd);
		else exp_q1.push_back(rd);
	end
endfunction

function automatic int pending(input int host);
	return (host == 0) ? exp_q0.size() : exp_q1.size();
endfunction

function automatic data_t pop_expected(input int host);
	return (host == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
endfunction

`endif

//--- test/mpss_tb.sv
module mpss_tb
	import mpss_pkg::*;
();

	logic clk_i;
	logic arst_n_i;
	logic [N_MASTERS-1:0] cmd_valid_i;
	bus_req_t cmd_i [N_MASTERS];
	logic [N_MASTERS-1:0] cmd_full_o;
	logic [N_MASTERS-1:0] rsp_valid_o;
	data_t rsp_rdata_o [N_MASTERS];
	data_t gpio_bi;
	data_t gpio_bo;

	int n_checks;
	int n_errors;
	int n_tests;
	int n_failed;
	int errs_at_start;
	string test_name;
	logic mon_en;
	logic full_seen;

	`include "mpss_tb_model.svh"

	mpss i_dut (
		.clk_i(clk_i)
		, .arst_n_i(arst_n_i)
		, .cmd_valid_i(cmd_valid_i)
		, .cmd_i(cmd_i)
		, .cmd_full_o(cmd_full_o)
		, .rsp_valid_o(rsp_valid_o)
		, .rsp_rdata_o(rsp_rdata_o)
		, .gpio_bi(gpio_bi)
		, .gpio_bo(gpio_bo)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	task automatic check_data(input string name, input data_t exp, input data_t act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			$display("ERROR %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout: no progress while waiting for %s", what);
		$display("TEST FAILED");
		$finish;
	endtask

	// Read responses are checked in command order per host
	always @(negedge clk_i) begin
		if (mon_en) begin
			for (int h = 0; h < N_MASTERS; h++) begin
				if (rsp_valid_o[h] && pending(h) == 0) begin
					n_errors++;
					$display("%s: host %0d answered with no read pending", test_name, h);
				end else if (rsp_valid_o[h]) begin
					check_data($sformatf("%s host%0d read", test_name, h), pop_expected(h),
						rsp_rdata_o[h]);
				end
			end
			if (cmd_full_o[1]) full_seen = 1'b1;
		end
	end

	function automatic bus_req_t make_cmd(input logic we, input addr_t addr, input be_t be,
		input data_t wdata);
		bus_req_t cmd;
		cmd.we = we;
		cmd.addr = addr;
		cmd.be = be;
		cmd.wdata = wdata;
		return cmd;
	endfunction

	// Strobes one command on a falling edge
	task automatic send(input int host, input bus_req_t cmd);
		int waited;
		waited = 0;
		while (cmd_full_o[host]) begin
			@(negedge clk_i);
			waited++;
			if (waited > 500) abort_on_timeout("free command queue space");
		end
		cmd_valid_i[host] = 1'b1;
		cmd_i[host] = cmd;
		model_apply(host, cmd);
		@(negedge clk_i);
		cmd_valid_i[host] = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q0.size() + exp_q1.size() != 0) begin
			@(negedge clk_i);
			waited++;
			if (waited > 3000) abort_on_timeout("outstanding read responses");
		end
	endtask

	// Random traffic in words lo..lo+span-1 of one bank or of both when bank < 0
	task automatic run_stream(input int host, input int bank, input int lo, input int span,
		input int n);
		int b;
		for (int i = 0; i < n; i++) begin
			b = (bank < 0) ? int'($urandom_range(1, 0)) : bank;
			send(host, make_cmd($urandom_range(1, 0),
				ram_addr(b, lo + $urandom_range(span - 1, 0)), be_t'($urandom), $urandom));
		end
		send(host, make_cmd(1'b0, ram_addr(0, lo), '0, '0)); // Closing read drains the host
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errs_at_start = n_errors;
	endtask

	task automatic end_test();
		n_tests++;
		if (n_errors == errs_at_start) begin
			$display("%s: passed", test_name);
		end else begin
			n_failed++;
			$display("%s: failed with %0d errors", test_name, n_errors - errs_at_start);
		end
	endtask

	initial begin
		addr_t addrs [8];
		data_t unm_word;
		void'($urandom(16307));
		n_checks = 0;
		n_errors = 0;
		n_tests = 0;
		n_failed = 0;
		mon_en = 1'b0;
		full_seen = 1'b0;
		arst_n_i = 1'b0;
		cmd_valid_i = '0;
		cmd_i[0] = '0;
		cmd_i[1] = '0;
		gpio_bi = '0;
		model_gpio_in = '0;
		model_gpio_out = '0;
		repeat (10) @(negedge clk_i);
		arst_n_i = 1'b1;
		repeat (3) @(negedge clk_i); // Reset synchroniser release
		mon_en = 1'b1;

		begin_test("t1_reset_state");
		for (int h = 0; h < N_MASTERS; h++) begin
			check_flag($sformatf("t1 rsp_valid host%0d", h), 1'b0, rsp_valid_o[h]);
			check_flag($sformatf("t1 cmd_full host%0d", h), 1'b0, cmd_full_o[h]);
		end
		check_data("t1 gpio_bo", '0, gpio_bo);
		end_test();

		begin_test("t2_host0_byte_enables");
		for (int i = 0; i < 32; i++) begin
			send(0, make_cmd(1'b1, ram_addr(0, i), 4'hf, $urandom));
			send(0, make_cmd(1'b1, ram_addr(1, i), 4'hf, $urandom));
		end
		for (int i = 0; i < 8; i++) begin
			addrs[i] = ram_addr(i % 2, $urandom_range(31, 0));
			send(0, make_cmd(1'b1, addrs[i], be_t'($urandom), $urandom));
		end
		for (int i = 0; i < 8; i++) begin
			send(0, make_cmd(1'b0, addrs[i], '0, '0));
		end
		wait_drain();
		end_test();

		begin_test("t3_concurrent_hosts");
		fork
			run_stream(0, -1, 0, 16, 24);
			run_stream(1, -1, 16, 16, 24);
		join
		wait_drain();
		end_test();

		begin_test("t4_gpio");
		send(1, make_cmd(1'b1, map_addr(2, GPIO_OUT_OFS), be_t'($urandom_range(15, 1)),
			$urandom));
		send(1, make_cmd(1'b0, map_addr(2, GPIO_OUT_OFS), '0, '0));
		wait_drain();
		check_data("t4 gpio_bo", model_gpio_out, gpio_bo);
		gpio_bi = $urandom;
		model_gpio_in = gpio_bi;
		repeat (5) @(negedge clk_i); // Input synchroniser
		send(1, make_cmd(1'b0, map_addr(2, GPIO_IN_OFS), '0, '0));
		wait_drain();
		end_test();

		begin_test("t5_unmapped");
		unm_word = $urandom;
		send(0, make_cmd(1'b0, map_addr(3, 8), '0, '0));
		send(0, make_cmd(1'b1, ram_addr(3, 5), 4'hf, unm_word));
		send(0, make_cmd(1'b1, map_addr(3, GPIO_OUT_OFS), 4'hf, ~unm_word));
		send(0, make_cmd(1'b0, ram_addr(0, 5), '0, '0));
		send(0, make_cmd(1'b0, ram_addr(1, 5), '0, '0));
		send(0, make_cmd(1'b0, map_addr(2, GPIO_OUT_OFS), '0, '0));
		wait_drain();
		check_data("t5 gpio_bo", model_gpio_out, gpio_bo);
		end_test();

		begin_test("t6_back_pressure");
		full_seen = 1'b0;
		fork
			run_stream(0, 1, 0, 16, 16);
			// Each write is read back by the next command
			for (int i = 0; i < 8; i++) begin
				send(1, make_cmd(i % 2 == 0, ram_addr(1, 16 + i / 2),
					be_t'($urandom), $urandom));
			end
		join
		wait_drain();
		check_flag("t6 cmd_full host1 seen", 1'b1, full_seen);
		end_test();

		$display("%0d tests, %0d failed, %0d checks, %0d errors", n_tests, n_failed, n_checks,
			n_errors);
		if (n_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+test
logic/mpss_pkg.sv
logic/reset_cntrl.sv
logic/bus_host.sv
logic/xbar_buffered.sv
logic/ram_bank.sv
logic/gpio.sv
logic/mpss.sv
test/mpss_tb.sv

//--- Bender.yml
package:
  name: mpss

sources:
  - files:
      - logic/mpss_pkg.sv
      - logic/reset_cntrl.sv
      - logic/bus_host.sv
      - logic/xbar_buffered.sv
      - logic/ram_bank.sv
      - logic/gpio.sv
      - logic/mpss.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/mpss_tb.sv
